// ==== list.f ====
source/cdc_fifo_pkg.sv
source/cdc_fifo_ram_rd_if.sv
source/cdc_fifo_gray_sync.sv
source/cdc_fifo_push_ctrl.sv
source/cdc_fifo_pop_ctrl.sv
source/cdc_fifo_flop_ram.sv
source/cdc_fifo_top.sv
tests/cdc_fifo_chk.sv
tests/cdc_fifo_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CDC FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module cdc_fifo_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/Vcdc_fifo_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
  exit 1
fi
exit 0

// ==== source/cdc_fifo_flop_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// Flop storage for the CDC FIFO, one write port on push_clk
// and one registered read port on pop_clk

module cdc_fifo_flop_ram #(
  parameter int DEPTH = cdc_fifo_pkg::DEFAULT_DEPTH,
  parameter int WIDTH = cdc_fifo_pkg::DEFAULT_WIDTH,
  localparam int AW = $clog2(DEPTH)
) (
  input  logic             push_clk,
  input  logic             pop_clk,

  // Write port, push domain
  input  logic             wr_valid,
  input  logic [AW-1:0]    wr_addr,
  input  logic [WIDTH-1:0] wr_data,

  // Read port, pop domain
  cdc_fifo_ram_rd_if.mem   rd
);

  logic [WIDTH-1:0] mem [DEPTH];

  // ------------------------------
  // Write side
  // ------------------------------

  always_ff @(posedge push_clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ------------------------------
  // Read side
  // ------------------------------

  // An entry is only read once its push count has crossed the synchronizers,
  // so it has long been stable in the array when pop_clk samples it
  always_ff @(posedge pop_clk) begin
    rd.rd_data_valid <= rd.rd_addr_valid;
    if (rd.rd_addr_valid) begin
      rd.rd_data <= mem[rd.rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== source/cdc_fifo_gray_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

// Flop chain that brings a gray count into another clock domain

module cdc_fifo_gray_sync #(
  parameter int DEPTH       = cdc_fifo_pkg::DEFAULT_DEPTH,
  parameter int SYNC_STAGES = cdc_fifo_pkg::DEFAULT_SYNC_STAGES,
  localparam int CW = $clog2(DEPTH) + 1
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic [CW-1:0] gray_in,
  output logic [CW-1:0] gray_out
);

  // Stage 0 may go metastable, the later stages give it time to settle
  logic [CW-1:0] sync_q [SYNC_STAGES];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= gray_in;
      // Shift toward the output end
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // One bit changes per count step, so the output is always the old or new count
  assign gray_out = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== source/cdc_fifo_pkg.sv ====
`default_nettype none

// Shared sizes and gray code helpers for the CDC FIFO
// Both clock domains convert their counts with the same functions

package cdc_fifo_pkg;

  // Default geometry of the FIFO, overridden at the top level
  localparam int DEFAULT_DEPTH       = 8;
  localparam int DEFAULT_WIDTH       = 16;
  localparam int DEFAULT_SYNC_STAGES = 2;

  // Word size the conversion functions work on; callers size in and out with casts
  localparam int CONV_WIDTH = 32;

  // Binary count to gray code; neighbouring counts differ in one bit
  function automatic logic [CONV_WIDTH-1:0] bin_to_gray(input logic [CONV_WIDTH-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // Gray code back to binary
  // Each binary bit is the XOR of all gray bits at and above it
  function automatic logic [CONV_WIDTH-1:0] gray_to_bin(input logic [CONV_WIDTH-1:0] gray);
    logic [CONV_WIDTH-1:0] bin;
    bin[CONV_WIDTH-1] = gray[CONV_WIDTH-1];
    for (int i = CONV_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// ==== source/cdc_fifo_pop_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// Pop-domain control of the CDC FIFO
// Issues RAM reads into a two-entry staging buffer and runs the ready/valid pop port

module cdc_fifo_pop_ctrl #(
  parameter int DEPTH = cdc_fifo_pkg::DEFAULT_DEPTH,
  parameter int WIDTH = cdc_fifo_pkg::DEFAULT_WIDTH,
  localparam int AW = $clog2(DEPTH),
  localparam int CW = $clog2(DEPTH) + 1
) (
  input  logic             pop_clk,
  input  logic             rst_n,

  // Ready/valid pop interface
  input  logic             pop_ready,
  output logic             pop_valid,
  output logic [WIDTH-1:0] pop_data,

  // Pop-side status
  output logic             pop_empty,
  output logic [CW-1:0]    pop_items,

  // Read port of the RAM
  cdc_fifo_ram_rd_if.ctrl  rd,

  // Counts crossing the domain boundary
  output logic [CW-1:0]    pop_count_gray,
  input  logic [CW-1:0]    pop_side_push_gray
);

  import cdc_fifo_pkg::*;

  logic [CW-1:0]    push_count_sync;
  // Read pointer runs ahead of the pop count by what is staged or in flight
  logic [CW-1:0]    rd_count;
  logic [CW-1:0]    pop_count;
  logic [CW-1:0]    pop_count_next;
  logic             has_unread;
  logic             rd_issue;
  logic             pop_fire;
  // Two-entry staging buffer
  logic [WIDTH-1:0] stage_data [2];
  logic             stage_wr_sel;
  logic             stage_rd_sel;
  logic [1:0]       stage_cnt;
  logic [1:0]       held_cnt;

  assign push_count_sync = CW'(gray_to_bin(CONV_WIDTH'(pop_side_push_gray)));

  // ------------------------------
  // Read issue
  // ------------------------------

  assign has_unread = (push_count_sync != rd_count);

  // Entries held next cycle are the staged ones plus the one arriving now
  assign held_cnt = stage_cnt + 2'(rd.rd_data_valid);

  // A read issued now lands in the buffer two cycles on, so a pop this cycle
  // already makes room for it and the stream runs without bubbles
  assign rd_issue = has_unread && ((held_cnt < 2'd2) || pop_fire);

  assign rd.rd_addr_valid = rd_issue;
  assign rd.rd_addr       = rd_count[AW-1:0];

  // ------------------------------
  // Staging buffer and pop port
  // ------------------------------

  assign pop_valid = (stage_cnt != 2'd0);
  assign pop_data  = stage_data[stage_rd_sel];
  assign pop_fire  = pop_valid && pop_ready;

  assign pop_count_next = pop_count + CW'(pop_fire);

  // Payload only, the valid state lives in stage_cnt
  always_ff @(posedge pop_clk) begin
    if (rd.rd_data_valid) begin
      stage_data[stage_wr_sel] <= rd.rd_data;
    end
  end

  always_ff @(posedge pop_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_count       <= '0;
      pop_count      <= '0;
      pop_count_gray <= '0;
      stage_wr_sel   <= 1'b0;
      stage_rd_sel   <= 1'b0;
      stage_cnt      <= 2'd0;
      pop_items      <= '0;
      pop_empty      <= 1'b1;
    end else begin
      if (rd_issue) begin
        rd_count <= rd_count + CW'(1);
      end
      if (rd.rd_data_valid) begin
        stage_wr_sel <= ~stage_wr_sel;
      end
      if (pop_fire) begin
        stage_rd_sel   <= ~stage_rd_sel;
        pop_count      <= pop_count_next;
        // The freed slot becomes visible to the push side through this count
        pop_count_gray <= CW'(bin_to_gray(CONV_WIDTH'(pop_count_next)));
      end
      stage_cnt <= stage_cnt + 2'(rd.rd_data_valid) - 2'(pop_fire);
      // Items include those still in the RAM, in flight or staged
      pop_items <= push_count_sync - pop_count_next;
      pop_empty <= (push_count_sync == pop_count_next);
    end
  end

endmodule

`default_nettype wire

// ==== source/cdc_fifo_push_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// Push-domain control of the CDC FIFO
// Hands out credits for free slots, writes the RAM and keeps the gray push count

module cdc_fifo_push_ctrl #(
  parameter int DEPTH = cdc_fifo_pkg::DEFAULT_DEPTH,
  parameter int WIDTH = cdc_fifo_pkg::DEFAULT_WIDTH,
  localparam int AW = $clog2(DEPTH),
  localparam int CW = $clog2(DEPTH) + 1
) (
  input  logic             push_clk,
  input  logic             rst_n,

  // Credit/valid push interface
  input  logic             push_credit_stall,
  output logic             push_credit,
  input  logic             push_valid,
  input  logic [WIDTH-1:0] push_data,

  // Push-side status
  output logic             push_full,
  output logic [CW-1:0]    push_slots,

  // Write port of the RAM
  output logic             wr_valid,
  output logic [AW-1:0]    wr_addr,
  output logic [WIDTH-1:0] wr_data,

  // Counts crossing the domain boundary
  output logic [CW-1:0]    push_count_gray,
  input  logic [CW-1:0]    push_side_pop_gray
);

  import cdc_fifo_pkg::*;

  // Running count of accepted pushes, one bit wider than the address
  logic [CW-1:0] push_count;
  logic [CW-1:0] push_count_next;
  // Pop count as seen in this domain, current and last cycle
  logic [CW-1:0] pop_count_sync;
  logic [CW-1:0] pop_count_seen;
  logic [CW-1:0] pop_step;
  // Credits owed to the sender but not yet handed out
  logic [CW-1:0] credits_owed;
  logic          credit_issue;
  logic [CW-1:0] slots_next;

  // ------------------------------
  // RAM write path
  // ------------------------------

  // Each accepted push lands at the low bits of the push count
  assign wr_valid = push_valid;
  assign wr_addr  = push_count[AW-1:0];
  assign wr_data  = push_data;

  assign push_count_next = push_count + CW'(push_valid);

  // ------------------------------
  // Credit return
  // ------------------------------

  // The synchronized gray count is safe to decode, only one bit moves per step
  assign pop_count_sync = CW'(gray_to_bin(CONV_WIDTH'(push_side_pop_gray)));

  // Slots freed since last cycle; a synchronized count can jump by more than one
  assign pop_step = pop_count_sync - pop_count_seen;

  // One credit per cycle while some are owed and the sender does not stall
  assign credit_issue = (credits_owed != '0) && !push_credit_stall;

  // Free slots after this cycle's push, judged against the freed pop count
  assign slots_next = CW'(DEPTH) - (push_count_next - pop_count_sync);

  always_ff @(posedge push_clk or negedge rst_n) begin
    if (!rst_n) begin
      push_count      <= '0;
      push_count_gray <= '0;
      pop_count_seen  <= '0;
      // Every slot is free after reset, so all of them are owed as credits
      credits_owed    <= CW'(DEPTH);
      push_credit     <= 1'b0;
      push_slots      <= CW'(DEPTH);
      push_full       <= 1'b0;
    end else begin
      // Credits stalled now stay in the counter and go out later
      credits_owed   <= credits_owed + pop_step - CW'(credit_issue);
      push_credit    <= credit_issue;
      pop_count_seen <= pop_count_sync;

      // The gray form moves with the count, on the same edge as the RAM write
      if (push_valid) begin
        push_count      <= push_count_next;
        push_count_gray <= CW'(bin_to_gray(CONV_WIDTH'(push_count_next)));
      end

      // Status settles one cycle after the push
      push_slots <= slots_next;
      push_full  <= (slots_next == '0);
    end
  end

endmodule

`default_nettype wire

// ==== source/cdc_fifo_ram_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Pop-side read port of the FIFO storage
// The request goes out on pop_clk and the data comes back one cycle later

interface cdc_fifo_ram_rd_if #(
  parameter int DEPTH = cdc_fifo_pkg::DEFAULT_DEPTH,
  parameter int WIDTH = cdc_fifo_pkg::DEFAULT_WIDTH
);
  localparam int AW = $clog2(DEPTH);

  // Request side
  logic             rd_addr_valid;
  logic [AW-1:0]    rd_addr;
  // Return side, valid exactly one pop_clk after the request
  logic             rd_data_valid;
  logic [WIDTH-1:0] rd_data;

  modport ctrl (output rd_addr_valid, output rd_addr, input rd_data_valid, input rd_data);
  modport mem  (input rd_addr_valid, input rd_addr, output rd_data_valid, output rd_data);

endinterface

`default_nettype wire

// ==== source/cdc_fifo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// CDC FIFO top level, credit/valid push on push_clk and ready/valid pop on pop_clk

module cdc_fifo_top #(
  parameter int DEPTH       = cdc_fifo_pkg::DEFAULT_DEPTH,
  parameter int WIDTH       = cdc_fifo_pkg::DEFAULT_WIDTH,
  parameter int SYNC_STAGES = cdc_fifo_pkg::DEFAULT_SYNC_STAGES,
  localparam int AW = $clog2(DEPTH),
  localparam int CW = $clog2(DEPTH) + 1
) (
  input  logic             push_clk,
  input  logic             pop_clk,
  input  logic             rst_n,

  // Push side
  input  logic             push_credit_stall,
  output logic             push_credit,
  input  logic             push_valid,
  input  logic [WIDTH-1:0] push_data,
  output logic             push_full,
  output logic [CW-1:0]    push_slots,

  // Pop side
  input  logic             pop_ready,
  output logic             pop_valid,
  output logic [WIDTH-1:0] pop_data,
  output logic             pop_empty,
  output logic [CW-1:0]    pop_items
);

  // RAM write port, push domain
  logic             wr_valid;
  logic [AW-1:0]    wr_addr;
  logic [WIDTH-1:0] wr_data;

  // Gray counts before and after crossing
  logic [CW-1:0] push_count_gray;
  logic [CW-1:0] pop_side_push_gray;
  logic [CW-1:0] pop_count_gray;
  logic [CW-1:0] push_side_pop_gray;

  cdc_fifo_ram_rd_if #(.DEPTH(DEPTH), .WIDTH(WIDTH)) u_ram_rd ();

  cdc_fifo_push_ctrl #(.DEPTH(DEPTH), .WIDTH(WIDTH)) u_push_ctrl (
    .push_clk, .rst_n, .push_credit_stall, .push_credit, .push_valid, .push_data,
    .push_full, .push_slots, .wr_valid, .wr_addr, .wr_data,
    .push_count_gray, .push_side_pop_gray
  );

  // Push count into the pop domain
  cdc_fifo_gray_sync #(.DEPTH(DEPTH), .SYNC_STAGES(SYNC_STAGES)) u_push_count_sync (
    .clk(pop_clk), .rst_n, .gray_in(push_count_gray), .gray_out(pop_side_push_gray)
  );

  // Pop count back into the push domain, this closes the credit loop
  cdc_fifo_gray_sync #(.DEPTH(DEPTH), .SYNC_STAGES(SYNC_STAGES)) u_pop_count_sync (
    .clk(push_clk), .rst_n, .gray_in(pop_count_gray), .gray_out(push_side_pop_gray)
  );

  cdc_fifo_flop_ram #(.DEPTH(DEPTH), .WIDTH(WIDTH)) u_flop_ram (
    .push_clk, .pop_clk, .wr_valid, .wr_addr, .wr_data, .rd(u_ram_rd.mem)
  );

  cdc_fifo_pop_ctrl #(.DEPTH(DEPTH), .WIDTH(WIDTH)) u_pop_ctrl (
    .pop_clk, .rst_n, .pop_ready, .pop_valid, .pop_data, .pop_empty, .pop_items,
    .rd(u_ram_rd.ctrl), .pop_count_gray, .pop_side_push_gray
  );

endmodule

`default_nettype wire

// ==== tests/cdc_fifo_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

// Protocol and bound assertions on the CDC FIFO top-level ports

module cdc_fifo_chk #(
  parameter int DEPTH = cdc_fifo_pkg::DEFAULT_DEPTH,
  parameter int WIDTH = cdc_fifo_pkg::DEFAULT_WIDTH,
  localparam int CW = $clog2(DEPTH) + 1
) (
  input logic             push_clk,
  input logic             pop_clk,
  input logic             rst_n,
  input logic             push_full,
  input logic [CW-1:0]    push_slots,
  input logic             pop_valid,
  input logic             pop_ready,
  input logic [WIDTH-1:0] pop_data,
  input logic [CW-1:0]    pop_items
);

  // Number of assertion failures over the run
  int assert_fails = 0;

  // A stalled item stays on the port unchanged
  pop_hold: assert property (@(posedge pop_clk) disable iff (!rst_n)
    (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_data)))
    else begin
      $error("pop_data changed under stall");
      assert_fails++;
    end

  slots_bound: assert property (@(posedge push_clk) disable iff (!rst_n)
    push_slots <= CW'(DEPTH))
    else begin
      $error("push_slots above DEPTH");
      assert_fails++;
    end

  items_bound: assert property (@(posedge pop_clk) disable iff (!rst_n)
    pop_items <= CW'(DEPTH))
    else begin
      $error("pop_items above DEPTH");
      assert_fails++;
    end

  // Full flag and slot count move together
  full_match: assert property (@(posedge push_clk) disable iff (!rst_n)
    push_full == (push_slots == '0))
    else begin
      $error("push_full disagrees with push_slots");
      assert_fails++;
    end

endmodule

bind cdc_fifo_top cdc_fifo_chk #(.DEPTH(DEPTH), .WIDTH(WIDTH)) u_cdc_fifo_chk (
  .push_clk, .pop_clk, .rst_n, .push_full, .push_slots,
  .pop_valid, .pop_ready, .pop_data, .pop_items
);

`default_nettype wire

// ==== tests/cdc_fifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Testbench for the CDC FIFO
// Credit-aware sender on push_clk, random-ready receiver on pop_clk, queue model

module cdc_fifo_tb;

  import cdc_fifo_pkg::*;

  localparam int DEPTH   = DEFAULT_DEPTH;
  localparam int WIDTH   = DEFAULT_WIDTH;
  localparam int CW      = $clog2(DEPTH) + 1;
  localparam int TIMEOUT = 5000;

  logic push_clk = 1'b0;
  logic pop_clk = 1'b0;
  logic rst_n = 1'b0;
  logic push_credit_stall = 1'b1;
  logic push_valid = 1'b0;
  logic [WIDTH-1:0] push_data = '0;
  logic pop_ready = 1'b0;
  logic push_credit, push_full, pop_valid, pop_empty;
  logic [CW-1:0] push_slots, pop_items;
  logic [WIDTH-1:0] pop_data;

  integer seed = 30;
  int errors = 0;
  int checks = 0;
  // Sender and receiver state, shared with the test sequence
  logic [WIDTH-1:0] model_q [$];
  int credits_held = 0;
  int credits_rx = 0;
  int push_budget = 0;
  bit push_rand = 1'b0;
  int pop_mode = 0;
  int popped = 0;

  always #2 push_clk = ~push_clk;
  always #3 pop_clk = ~pop_clk;

  cdc_fifo_top #(.DEPTH(DEPTH), .WIDTH(WIDTH), .SYNC_STAGES(DEFAULT_SYNC_STAGES)) u_cdc_fifo_top (
    .push_clk, .pop_clk, .rst_n, .push_credit_stall, .push_credit, .push_valid, .push_data,
    .push_full, .push_slots, .pop_ready, .pop_valid, .pop_data, .pop_empty, .pop_items
  );

  // Oldest value still in the FIFO according to the push order
  function automatic logic [WIDTH-1:0] expected_pop();
    return model_q[0];
  endfunction

  task automatic check_data(input string name, input logic [WIDTH-1:0] got,
                            input logic [WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [CW-1:0] got,
                             input logic [CW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  task automatic end_test(input int num, input string name, input int errs_before);
    $display("Test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "errors");
  endtask

  // ------------------------------
  // Sender
  // ------------------------------

  // Counts each credit pulse once and spends one credit per push
  always @(negedge push_clk) begin
    push_valid = 1'b0;
    if (rst_n) begin
      if (push_credit) begin
        credits_held++;
        credits_rx++;
      end
      if (push_budget > 0 && credits_held > 0 && (!push_rand || $random(seed) % 2 == 0)) begin
        push_valid = 1'b1;
        push_data = WIDTH'($random(seed));
        model_q.push_back(push_data);
        credits_held--;
        push_budget--;
      end
    end
  end

  // ------------------------------
  // Receiver and compare
  // ------------------------------

  // Ready for the next rising edge is chosen first
  // An item on the port now transfers on that edge when ready is high
  always @(negedge pop_clk) begin
    if (rst_n) begin
      case (pop_mode)
        0: pop_ready = 1'b0;
        1: pop_ready = 1'b1;
        default: pop_ready = ($random(seed) % 3 != 0);
      endcase
      if (pop_valid && pop_ready) begin
        if (model_q.size() == 0) begin
          errors++;
          $display("Pop at %0t with no item left in the model", $time);
        end else begin
          check_data("pop_data", pop_data, expected_pop());
          void'(model_q.pop_front());
        end
        popped++;
      end
    end
  end

  initial begin
    int t;
    int e0;
    int base;
    int assert_errs;

    repeat (8) @(posedge push_clk);
    @(negedge push_clk);
    rst_n = 1'b1;

    // Test 1, state right after reset
    e0 = errors;
    check_flag("push_credit", push_credit, 1'b0);
    check_flag("pop_valid", pop_valid, 1'b0);
    check_flag("pop_empty", pop_empty, 1'b1);
    check_count("pop_items", pop_items, '0);
    check_flag("push_full", push_full, 1'b0);
    check_count("push_slots", push_slots, CW'(DEPTH));
    end_test(1, "after reset", e0);

    // Test 2, no credits under stall, then exactly DEPTH
    e0 = errors;
    repeat (20) @(negedge push_clk);
    check_count("credits under stall", CW'(credits_rx), '0);
    push_credit_stall = 1'b0;
    t = 0;
    while (credits_rx < DEPTH && t < TIMEOUT) begin
      @(negedge push_clk);
      t++;
    end
    if (credits_rx < DEPTH) report_timeout("the initial credits");
    repeat (20) @(negedge push_clk);
    check_count("initial credits", CW'(credits_rx), CW'(DEPTH));
    end_test(2, "credit grant", e0);

    // Test 3, random stream with random back-pressure
    e0 = errors;
    push_rand = 1'b1;
    pop_mode = 2;
    push_budget = 200;
    t = 0;
    while (popped < 200 && t < 20 * TIMEOUT) begin
      @(negedge pop_clk);
      t++;
    end
    if (popped < 200) report_timeout("200 pops");
    pop_mode = 0;
    push_rand = 1'b0;
    t = 0;
    while (credits_held < DEPTH && t < TIMEOUT) begin
      @(negedge push_clk);
      t++;
    end
    if (credits_held < DEPTH) report_timeout("the credits of the stream");
    end_test(3, "ordered transfer", e0);

    // Test 4, fill with the receiver stalled
    e0 = errors;
    base = credits_rx;
    push_budget = DEPTH;
    t = 0;
    while ((push_budget > 0 || !push_full) && t < TIMEOUT) begin
      @(negedge push_clk);
      t++;
    end
    if (!push_full) report_timeout("push_full");
    check_flag("push_full", push_full, 1'b1);
    check_count("push_slots", push_slots, '0);
    t = 0;
    while (pop_items != CW'(DEPTH) && t < TIMEOUT) begin
      @(negedge pop_clk);
      t++;
    end
    if (pop_items != CW'(DEPTH)) report_timeout("pop_items to reach DEPTH");
    check_flag("pop_valid", pop_valid, 1'b1);
    check_data("pop_data", pop_data, expected_pop());
    repeat (20) @(negedge push_clk);
    check_count("credits while full", CW'(credits_rx - base), '0);
    end_test(4, "fill", e0);

    // Test 5, drain and credit return
    e0 = errors;
    base = credits_rx;
    pop_mode = 1;
    t = 0;
    while ((popped < 200 + DEPTH || !pop_empty) && t < TIMEOUT) begin
      @(negedge pop_clk);
      t++;
    end
    if (popped < 200 + DEPTH) report_timeout("the drain");
    check_flag("pop_empty", pop_empty, 1'b1);
    t = 0;
    while (credits_rx - base < DEPTH && t < TIMEOUT) begin
      @(negedge push_clk);
      t++;
    end
    if (credits_rx - base < DEPTH) report_timeout("the returned credits");
    repeat (20) @(negedge push_clk);
    check_count("returned credits", CW'(credits_rx - base), CW'(DEPTH));
    end_test(5, "drain and return", e0);

    // Failed port assertions count against the run as well
    assert_errs = u_cdc_fifo_top.u_cdc_fifo_chk.assert_fails;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d, items popped: %0d",
             checks, errors, assert_errs, popped);
    if (errors == 0 && assert_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
